//--- rtl/mmr_pkg.sv
// shared types and constants for the CPS-A / CPS-B register block
// covers the CPU bus cycle, the CPS-B configuration map, the mapper
// fields and the grouped register outputs of both chips
package mmr_pkg;

    // configuration chain length in bytes
    localparam int cfg_bytes = 24;

    // word address that disables a gated CPS-B slot
    localparam logic [4:0] addr_off = 5'd31;

    // layer order 3-2-1-0, all palette pages enabled
    localparam logic [15:0] layer_ctrl_rst = {3'b000, 2'b11, 2'b10, 2'b01, 2'b00, 5'd0};
    localparam logic [5:0]  pal_page_rst   = 6'h3f;

    // CPS-A fixed word addresses
    localparam logic [4:0] a_obj_base   = 5'h00;
    localparam logic [4:0] a_scr1_base  = 5'h01;
    localparam logic [4:0] a_scr2_base  = 5'h02;
    localparam logic [4:0] a_scr3_base  = 5'h03;
    localparam logic [4:0] a_row_base   = 5'h04;
    localparam logic [4:0] a_pal_base   = 5'h05;
    localparam logic [4:0] a_hpos1      = 5'h06;
    localparam logic [4:0] a_vpos1      = 5'h07;
    localparam logic [4:0] a_hpos2      = 5'h08;
    localparam logic [4:0] a_vpos2      = 5'h09;
    localparam logic [4:0] a_hpos3      = 5'h0a;
    localparam logic [4:0] a_vpos3      = 5'h0b;
    localparam logic [4:0] a_hstar1     = 5'h0c;
    localparam logic [4:0] a_vstar1     = 5'h0d;
    localparam logic [4:0] a_hstar2     = 5'h0e;
    localparam logic [4:0] a_vstar2     = 5'h0f;
    localparam logic [4:0] a_row_offset = 5'h10;
    localparam logic [4:0] a_ppu_ctrl   = 5'h11;

    // one CPU bus cycle, dsn is active low per byte lane
    typedef struct packed {
        logic        cs_a;
        logic        cs_b;
        logic [4:0]  addr;
        logic [1:0]  dsn;
        logic [15:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [7:0] board_id;
        logic [4:0] id;
        logic [4:0] mult1;
        logic [4:0] mult2;
        logic [4:0] rslt0;
        logic [4:0] rslt1;
        logic [4:0] layer;
        logic [4:0] prio0;
        logic [4:0] prio1;
        logic [4:0] prio2;
        logic [4:0] prio3;
        logic [4:0] in2;
        logic [4:0] in3;
        logic [4:0] pal_page;
        logic [7:0] layer_mask0;
        logic [7:0] layer_mask1;
        logic [7:0] layer_mask2;
        logic [7:0] layer_mask3;
    } cpsb_map_t;

    typedef struct packed {
        logic [5:0]  game;
        logic [15:0] bank_offset;
        logic [15:0] bank_mask;
        logic        cpu_speed;
    } mapper_t;

    typedef struct packed {
        logic [15:0] hpos1, hpos2, hpos3;
        logic [15:0] vpos1, vpos2, vpos3;
        logic [15:0] hstar1, hstar2;
        logic [15:0] vstar1, vstar2;
    } scroll_t;

    typedef struct packed {
        logic [15:0] obj_base, scr1_base, scr2_base, scr3_base;
        logic [15:0] row_base, row_offset, pal_base, ppu_ctrl;
    } vram_t;

    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [15:0] prio0, prio1, prio2, prio3;
        logic [5:0]  pal_page_en;
    } mix_t;

    typedef struct packed {
        logic [3:0] start;
        logic [3:0] coin;
        logic [7:0] joy3;
        logic [7:0] joy4;
    } player_in_t;

endpackage

//--- rtl/cpsb_cfg_chain.sv
// CPS-B configuration chain
// bytes shift in one per cfg_we cycle and are decoded into the
// relocatable slot addresses, layer masks and ROM mapper fields
`timescale 1ns/1ps

module cpsb_cfg_chain (
    input  logic                clk,
    input  logic                reg_rst,
    input  logic                cfg_we,
    input  logic [7:0]          cfg_data,
    output mmr_pkg::cpsb_map_t  map,
    output mmr_pkg::mapper_t    mapper
);
    import mmr_pkg::*;

    logic [cfg_bytes-1:0][7:0] chain;

    // newest byte lands in byte 0, older ones move up
    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            chain <= '1;
        end else if (cfg_we) begin
            chain <= {chain[cfg_bytes-2:0], cfg_data};
        end
    end

    // address bytes are byte addresses, drop bit 0 for the word address
    always_comb begin
        map.id          = chain[0][5:1];
        map.board_id    = chain[1];
        map.mult1       = chain[2][5:1];
        map.mult2       = chain[3][5:1];
        map.rslt0       = chain[4][5:1];
        map.rslt1       = chain[5][5:1];
        map.layer       = chain[6][5:1];
        map.prio0       = chain[7][5:1];
        map.prio1       = chain[8][5:1];
        map.prio2       = chain[9][5:1];
        map.prio3       = chain[10][5:1];
        map.in2         = chain[11][5:1];
        map.in3         = chain[12][5:1];
        map.pal_page    = chain[13][5:1];
        map.layer_mask0 = chain[14];
        map.layer_mask1 = chain[15];
        map.layer_mask2 = chain[16];
        map.layer_mask3 = chain[17];
    end

    // ROM bank mapper, last six bytes
    always_comb begin
        mapper.game        = chain[18][5:0];
        mapper.bank_offset = {chain[20], chain[19]};
        mapper.bank_mask   = {chain[22], chain[21]};
        mapper.cpu_speed   = chain[23][0];
    end

    // a byte taken in must be fully defined, it steers the whole CPS-B map
    assert property (@(posedge clk) disable iff (reg_rst)
        cfg_we |-> !$isunknown(cfg_data))
        else $error("configuration byte unknown while cfg_we is high");

endmodule

//--- rtl/cpsa_regs.sv
// CPS-A register bank
// fixed word addresses 0 to 17 with byte lane merge on write
// palette base and object base writes arm a copy / DMA pulse that
// fires once the chip select has dropped
`timescale 1ns/1ps

module cpsa_regs (
    input  logic              clk,
    input  logic              reg_rst,
    input  mmr_pkg::bus_req_t bus,
    output mmr_pkg::scroll_t  scroll,
    output mmr_pkg::vram_t    vram,
    output logic              pal_copy,
    output logic              obj_dma_ok
);
    import mmr_pkg::*;

    logic pre_copy;
    logic pre_dma;
    logic [15:0] wd;
    logic [1:0]  dsn;

    // keep the old byte where its select is high
    function automatic logic [15:0] lane_merge(
        input logic [15:0] old_word,
        input logic [15:0] new_word,
        input logic [1:0]  sel_n
    );
        logic [7:0] hi;
        logic [7:0] lo;
        hi = sel_n[1] ? old_word[15:8] : new_word[15:8];
        lo = sel_n[0] ? old_word[7:0]  : new_word[7:0];
        return {hi, lo};
    endfunction

    assign wd  = bus.wdata;
    assign dsn = bus.dsn;

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            scroll     <= '0;
            vram       <= '0;
            pre_copy   <= 1'b0;
            pre_dma    <= 1'b0;
            pal_copy   <= 1'b0;
            obj_dma_ok <= 1'b0;
        end else if (bus.cs_a) begin
            pal_copy   <= 1'b0;
            obj_dma_ok <= 1'b0;
            case (bus.addr)
                a_obj_base: begin
                    vram.obj_base <= lane_merge(vram.obj_base, wd, dsn);
                    pre_dma       <= 1'b1;
                end
                a_scr1_base: vram.scr1_base <= lane_merge(vram.scr1_base, wd, dsn);
                a_scr2_base: vram.scr2_base <= lane_merge(vram.scr2_base, wd, dsn);
                a_scr3_base: vram.scr3_base <= lane_merge(vram.scr3_base, wd, dsn);
                a_row_base:  vram.row_base  <= lane_merge(vram.row_base, wd, dsn);
                a_pal_base: begin
                    vram.pal_base <= lane_merge(vram.pal_base, wd, dsn);
                    pre_copy      <= 1'b1;
                end
                a_hpos1:  scroll.hpos1  <= lane_merge(scroll.hpos1, wd, dsn);
                a_vpos1:  scroll.vpos1  <= lane_merge(scroll.vpos1, wd, dsn);
                a_hpos2:  scroll.hpos2  <= lane_merge(scroll.hpos2, wd, dsn);
                a_vpos2:  scroll.vpos2  <= lane_merge(scroll.vpos2, wd, dsn);
                a_hpos3:  scroll.hpos3  <= lane_merge(scroll.hpos3, wd, dsn);
                a_vpos3:  scroll.vpos3  <= lane_merge(scroll.vpos3, wd, dsn);
                a_hstar1: scroll.hstar1 <= lane_merge(scroll.hstar1, wd, dsn);
                a_vstar1: scroll.vstar1 <= lane_merge(scroll.vstar1, wd, dsn);
                a_hstar2: scroll.hstar2 <= lane_merge(scroll.hstar2, wd, dsn);
                a_vstar2: scroll.vstar2 <= lane_merge(scroll.vstar2, wd, dsn);
                a_row_offset: begin
                    vram.row_offset <= lane_merge(vram.row_offset, wd, dsn);
                end
                a_ppu_ctrl: vram.ppu_ctrl <= lane_merge(vram.ppu_ctrl, wd, dsn);
                default: begin
                    // addresses 18 to 31 hold nothing on CPS-A
                end
            endcase
        end else begin
            // the CPU may still be writing the base while cs_a is high,
            // so the pulse only goes out after the select drops
            pal_copy   <= pre_copy;
            obj_dma_ok <= pre_dma;
            pre_copy   <= 1'b0;
            pre_dma    <= 1'b0;
        end
    end

    // no palette copy while the CPU has CPS-A selected
    assert property (@(posedge clk) disable iff (reg_rst)
        pal_copy |-> !bus.cs_a)
        else $error("palette copy pulse while CPS-A is selected");

endmodule

//--- rtl/cpsb_regs.sv
// CPS-B register bank
// slot addresses come from the configuration chain, so every access
// is matched against the whole map; holds the 16x16 multiplier,
// layer and priority registers, extra player inputs and the
// registered read port
`timescale 1ns/1ps

module cpsb_regs (
    input  logic                clk,
    input  logic                reg_rst,
    input  mmr_pkg::bus_req_t   bus,
    input  mmr_pkg::cpsb_map_t  map,
    input  mmr_pkg::player_in_t players,
    output mmr_pkg::mix_t       mix,
    output logic [15:0]         rdata
);
    import mmr_pkg::*;

    logic hit_id, hit_mult1, hit_mult2, hit_rslt0, hit_rslt1, hit_layer;
    logic hit_prio0, hit_prio1, hit_prio2, hit_prio3;
    logic hit_in2, hit_in3, hit_pal_page;
    logic        wr_en;
    logic [15:0] mult1;
    logic [15:0] mult2;
    logic [31:0] product;
    logic [7:0]  in2;
    logic [7:0]  in3;
    logic [15:0] rd_mux;

    // gated slots are switched off when configured to addr_off
    function automatic logic slot_match(
        input logic [4:0] addr,
        input logic [4:0] slot,
        input logic       gated
    );
        return (addr == slot) && !(gated && (slot == addr_off));
    endfunction

    assign hit_id       = slot_match(bus.addr, map.id,       1'b0);
    assign hit_mult1    = slot_match(bus.addr, map.mult1,    1'b1);
    assign hit_mult2    = slot_match(bus.addr, map.mult2,    1'b1);
    assign hit_rslt0    = slot_match(bus.addr, map.rslt0,    1'b1);
    assign hit_rslt1    = slot_match(bus.addr, map.rslt1,    1'b1);
    assign hit_layer    = slot_match(bus.addr, map.layer,    1'b0);
    assign hit_prio0    = slot_match(bus.addr, map.prio0,    1'b1);
    assign hit_prio1    = slot_match(bus.addr, map.prio1,    1'b1);
    assign hit_prio2    = slot_match(bus.addr, map.prio2,    1'b1);
    assign hit_prio3    = slot_match(bus.addr, map.prio3,    1'b1);
    assign hit_in2      = slot_match(bus.addr, map.in2,      1'b1);
    assign hit_in3      = slot_match(bus.addr, map.in3,      1'b1);
    assign hit_pal_page = slot_match(bus.addr, map.pal_page, 1'b0);

    // only full word writes reach CPS-B
    assign wr_en = bus.cs_b && (bus.dsn == 2'b00);

    // extra inputs: start, coin, six joystick bits
    assign in2 = {players.start[2], players.coin[2], players.joy3[5:0]};
    assign in3 = {players.start[3], players.coin[3], players.joy4[5:0]};

    always_comb begin
        rd_mux = '1;
        if (bus.addr != addr_off) begin
            if (hit_id) begin
                rd_mux = {4'd0, map.board_id[7:4], 4'd0, map.board_id[3:0]};
            end else if (hit_mult1) begin
                rd_mux = mult1;
            end else if (hit_mult2) begin
                rd_mux = mult2;
            end else if (hit_rslt0) begin
                rd_mux = product[15:0];
            end else if (hit_rslt1) begin
                rd_mux = product[31:16];
            end else if (hit_layer) begin
                rd_mux = mix.layer_ctrl;
            end else if (hit_prio0) begin
                rd_mux = mix.prio0;
            end else if (hit_prio1) begin
                rd_mux = mix.prio1;
            end else if (hit_prio2) begin
                rd_mux = mix.prio2;
            end else if (hit_prio3) begin
                rd_mux = mix.prio3;
            end else if (hit_pal_page) begin
                rd_mux = {10'd0, mix.pal_page_en};
            end else if (hit_in2) begin
                rd_mux = {in2, in2};
            end else if (hit_in3) begin
                rd_mux = {in3, in3};
            end
        end
    end

    always_ff @(posedge clk or posedge reg_rst) begin
        if (reg_rst) begin
            mult1            <= '0;
            mult2            <= '0;
            product          <= '0;
            rdata            <= '1;
            mix.layer_ctrl   <= layer_ctrl_rst;
            mix.prio0        <= '0;
            mix.prio1        <= '0;
            mix.prio2        <= '0;
            mix.prio3        <= '0;
            mix.pal_page_en  <= pal_page_rst;
        end else begin
            // one cycle behind the operands
            product <= mult1 * mult2;
            if (bus.cs_b) begin
                rdata <= rd_mux;
            end
            if (wr_en) begin
                if (hit_mult1)    mult1           <= bus.wdata;
                if (hit_mult2)    mult2           <= bus.wdata;
                if (hit_layer)    mix.layer_ctrl  <= bus.wdata;
                if (hit_prio0)    mix.prio0       <= bus.wdata;
                if (hit_prio1)    mix.prio1       <= bus.wdata;
                if (hit_prio2)    mix.prio2       <= bus.wdata;
                if (hit_prio3)    mix.prio3       <= bus.wdata;
                if (hit_pal_page) mix.pal_page_en <= bus.wdata[5:0];
            end
        end
    end

    // the configuration must not place two slots on one live address
    assert property (@(posedge clk) disable iff (reg_rst)
        (bus.cs_b && (bus.addr != addr_off)) |->
        $onehot0({hit_id, hit_mult1, hit_mult2, hit_rslt0, hit_rslt1, hit_layer,
                  hit_prio0, hit_prio1, hit_prio2, hit_prio3,
                  hit_in2, hit_in3, hit_pal_page}))
        else $error("CPS-B slots overlap at address %0d", bus.addr);

endmodule

//--- rtl/mmr_top.sv
// register block top level for the two-chip video system
// joins the CPS-B configuration chain with the CPS-A and CPS-B
// register banks on one shared CPU bus
`timescale 1ns/1ps

module mmr_top (
    input  logic                clk,
    input  logic                reg_rst,
    input  mmr_pkg::bus_req_t   bus,
    input  logic                cfg_we,
    input  logic [7:0]          cfg_data,
    input  mmr_pkg::player_in_t players,
    output logic [15:0]         rdata,
    output mmr_pkg::scroll_t    scroll,
    output mmr_pkg::vram_t      vram,
    output mmr_pkg::mix_t       mix,
    output mmr_pkg::mapper_t    mapper,
    output logic                pal_copy,
    output logic                obj_dma_ok
);
    import mmr_pkg::*;

    // decoded CPS-B address map
    cpsb_map_t cfg_map;

    cpsb_cfg_chain cfg0 (
        .clk      (clk),
        .reg_rst  (reg_rst),
        .cfg_we   (cfg_we),
        .cfg_data (cfg_data),
        .map      (cfg_map),
        .mapper   (mapper)
    );

    // fixed-address chip
    cpsa_regs cpsa0 (
        .clk        (clk),
        .reg_rst    (reg_rst),
        .bus        (bus),
        .scroll     (scroll),
        .vram       (vram),
        .pal_copy   (pal_copy),
        .obj_dma_ok (obj_dma_ok)
    );

    // relocatable chip, also owns the read port
    cpsb_regs cpsb0 (
        .clk     (clk),
        .reg_rst (reg_rst),
        .bus     (bus),
        .map     (cfg_map),
        .players (players),
        .mix     (mix),
        .rdata   (rdata)
    );

endmodule

//--- test/mmr_tb.sv
// testbench for the CPS-A / CPS-B register block
// reads commands and expected values from the stimulus file, drives the
// CPU bus and the configuration chain, and compares the DUT outputs
`timescale 1ns/1ps

module mmr_tb;
    import mmr_pkg::*;

    logic        clk;
    logic        reg_rst;
    bus_req_t    bus;
    logic        cfg_we;
    logic [7:0]  cfg_data;
    player_in_t  players;
    logic [15:0] rdata;
    scroll_t     scroll;
    vram_t       vram;
    mix_t        mix;
    mapper_t     mapper;
    logic        pal_copy;
    logic        obj_dma_ok;

    int mismatches;
    int failures;

    mmr_top dut0 (
        .clk        (clk),
        .reg_rst    (reg_rst),
        .bus        (bus),
        .cfg_we     (cfg_we),
        .cfg_data   (cfg_data),
        .players    (players),
        .rdata      (rdata),
        .scroll     (scroll),
        .vram       (vram),
        .mix        (mix),
        .mapper     (mapper),
        .pal_copy   (pal_copy),
        .obj_dma_ok (obj_dma_ok)
    );

    always #5 clk = ~clk;

    task automatic check_word(input string what, input logic [15:0] exp,
                              input logic [15:0] act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, what, exp, act);
        end
    endtask

    task automatic check_scroll(input scroll_t exp, input scroll_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: scroll expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic check_mapper(input mapper_t exp, input mapper_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: mapper expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic check_mix(input mix_t exp, input mix_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: mix expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic check_pulse(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %b got %b", $time, what, exp, act);
        end
    endtask

    task automatic bus_idle();
        bus = {1'b0, 1'b0, 5'd0, 2'b11, 16'h0000};
    endtask

    task automatic shift_cfg_byte(input logic [7:0] b);
        cfg_we   = 1'b1;
        cfg_data = b;
        @(negedge clk);
        cfg_we   = 1'b0;
    endtask

    // cs_a stays high for the given cycles, no pulse may show meanwhile
    task automatic cpsa_write(input logic [4:0] addr, input logic [1:0] dsn,
                              input logic [15:0] data, input int cycles);
        bus = {1'b1, 1'b0, addr, dsn, data};
        repeat (cycles) begin
            @(negedge clk);
            check_pulse("pal_copy", 1'b0, pal_copy);
            check_pulse("obj_dma_ok", 1'b0, obj_dma_ok);
        end
        bus_idle();
    endtask

    task automatic cpsb_write(input logic [4:0] addr, input logic [15:0] data);
        bus = {1'b0, 1'b1, addr, 2'b00, data};
        @(negedge clk);
        bus_idle();
    endtask

    // rdata follows the edge that sampled cs_b
    task automatic read_expect(input logic [4:0] addr, input logic [15:0] exp);
        bus = {1'b0, 1'b1, addr, 2'b11, 16'h0000};
        @(negedge clk);
        bus_idle();
        check_word($sformatf("rdata at %0h", addr), exp, rdata);
    endtask

    task automatic wait_pulse(input int which);
        int    n;
        logic  seen;
        string name;
        name = (which != 0) ? "obj_dma_ok" : "pal_copy";
        seen = 1'b0;
        n = 0;
        while (!seen && n < 4) begin
            @(negedge clk);
            seen = (which != 0) ? obj_dma_ok : pal_copy;
            n++;
        end
        if (!seen) begin
            failures++;
            $display("timeout at %0t: no %s pulse within 4 cycles", $time, name);
        end else begin
            @(negedge clk);
            check_pulse(name, 1'b0, (which != 0) ? obj_dma_ok : pal_copy);
        end
    endtask

    initial begin
        int          fd;
        string       line;
        byte         op;
        logic [31:0] v0, v1, v2, v3, v4, v5, v6, v7, v8, v9;
        logic [31:0] a [10];
        mismatches = 0;
        failures   = 0;
        clk        = 1'b0;
        reg_rst    = 1'b1;
        cfg_we     = 1'b0;
        cfg_data   = 8'h00;
        players    = '0;
        bus_idle();
        repeat (8) @(negedge clk);
        reg_rst = 1'b0;
        fd = $fopen("test/mmr_stim.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open the stimulus file test/mmr_stim.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h",
                                  op, v0, v1, v2, v3, v4, v5, v6, v7, v8, v9));
                    a = '{v0, v1, v2, v3, v4, v5, v6, v7, v8, v9};
                    case (op)
                        "C": for (int i = 0; i < 8; i++) shift_cfg_byte(a[i][7:0]);
                        "A": cpsa_write(v0[4:0], v1[1:0], v2[15:0], 1);
                        "H": cpsa_write(v0[4:0], v1[1:0], v2[15:0], v3);
                        "B": cpsb_write(v0[4:0], v1[15:0]);
                        "R": read_expect(v0[4:0], v1[15:0]);
                        "S": check_scroll({a[0][15:0], a[1][15:0], a[2][15:0], a[3][15:0],
                                           a[4][15:0], a[5][15:0], a[6][15:0], a[7][15:0],
                                           a[8][15:0], a[9][15:0]}, scroll);
                        "O": check_word("row_offset", v0[15:0], vram.row_offset);
                        "M": check_mapper({v0[5:0], v1[15:0], v2[15:0], v3[0]}, mapper);
                        "X": check_mix({v0[15:0], v1[15:0], v2[15:0], v3[15:0], v4[15:0],
                                        v5[5:0]}, mix);
                        "W": wait_pulse(v0);
                        "N": players = {v0[3:0], v1[3:0], v2[7:0], v3[7:0]};
                        "I": repeat (v0) @(negedge clk);
                        default: begin
                            failures++;
                            $display("unknown command in stimulus file: %s", line);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- build.f
rtl/mmr_pkg.sv
rtl/cpsb_cfg_chain.sv
rtl/cpsa_regs.sv
rtl/cpsb_regs.sv
rtl/mmr_top.sv
test/mmr_tb.sv

//--- test/mmr_stim.txt
# op then hex fields: C eight config bytes, A/H addr dsn data [cycles], B addr data, R addr word
# S ten scroll words, O row_offset, M game offset mask speed, X mix, W 0 pal 1 obj, N players, I n
R 00 ffff
R 1f ffff
X 1c80 0000 0000 0000 0000 3f
C 01 00 ff 12 34 0b 08 30
C 24 02 30 2e 2c 2a 28 26
C 24 22 20 1e 1c 1a 59 32
M 0b 1234 00ff 1
A 06 0 1234
A 06 2 ab55
A 06 1 cd77
A 06 3 ffff
A 0f 0 8765
A 0f 1 2200
A 10 0 0f0f
A 10 2 ff33
S cd55 0 0 0 0 0 0 0 0 2265
O 0f33
H 05 0 0400 3
W 0
H 00 0 0900 3
W 1
B 0d 1234
B 0e 5678
I 2
R 0f 0060
R 10 0626
R 19 0509
B 12 a001
B 13 b002
B 14 c003
B 15 d004
R 14 c003
X 1c80 a001 b002 c003 d004 3f
C 01 00 ff 12 34 0b 08 30
C 24 02 30 2e 2c 2a 3e 26
C 24 22 20 1e 1c 1a 59 32
B 1f eeee
X 1c80 a001 b002 c003 d004 3f
R 1f ffff
R 14 ffff
R 03 ffff
N c a 3f 2a
R 16 bfbf
R 17 eaea
